// File: src/periph_pkg.sv
// Shared bus widths, vector types and byte-strobe helpers

package periph_pkg;

    // Bus widths
    localparam int XLEN  = 32;
    localparam int ADDRW = 16;
    localparam int STRBW = XLEN / 8;

    typedef logic [XLEN-1:0]  data_t;
    typedef logic [ADDRW-1:0] addr_t;
    typedef logic [STRBW-1:0] strb_t;

    // One byte of ones per set strobe bit
    function automatic data_t strb_mask(input strb_t strb);
        data_t mask;
        mask = '0;
        for (int i = 0; i < STRBW; i++) begin
            mask[i*8 +: 8] = {8{strb[i]}};
        end
        return mask;
    endfunction

    // Takes the strobed bytes from new_word, the rest from old_word
    function automatic data_t strb_merge(
        input data_t old_word,
        input data_t new_word,
        input strb_t strb
    );
        data_t mask;
        mask = strb_mask(strb);
        return (old_word & ~mask) | (new_word & mask);
    endfunction

endpackage

// File: src/apb_interconnect.sv
// Register-access interconnect: window decode, offset rebase, forwarding
// to three targets and immediate completion of unmapped accesses

`timescale 1ns/100ps

module apb_interconnect #(
    parameter int SLV0_ADDR = 0,
    parameter int SLV0_SIZE = 8,
    parameter int SLV1_ADDR = 8,
    parameter int SLV1_SIZE = 4,
    parameter int SLV2_ADDR = 12,
    parameter int SLV2_SIZE = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    // Requester side
    input  logic              slv_en,
    input  logic              slv_wr,
    input  periph_pkg::addr_t slv_addr,
    input  periph_pkg::data_t slv_wdata,
    input  periph_pkg::strb_t slv_strb,
    output periph_pkg::data_t slv_rdata,
    output logic              slv_ready,
    // Target 0
    output logic              mst0_en,
    output logic              mst0_wr,
    output periph_pkg::addr_t mst0_addr,
    output periph_pkg::data_t mst0_wdata,
    output periph_pkg::strb_t mst0_strb,
    input  periph_pkg::data_t mst0_rdata,
    input  logic              mst0_ready,
    // Target 1
    output logic              mst1_en,
    output logic              mst1_wr,
    output periph_pkg::addr_t mst1_addr,
    output periph_pkg::data_t mst1_wdata,
    output periph_pkg::strb_t mst1_strb,
    input  periph_pkg::data_t mst1_rdata,
    input  logic              mst1_ready,
    // Target 2
    output logic              mst2_en,
    output logic              mst2_wr,
    output periph_pkg::addr_t mst2_addr,
    output periph_pkg::data_t mst2_wdata,
    output periph_pkg::strb_t mst2_strb,
    input  periph_pkg::data_t mst2_rdata,
    input  logic              mst2_ready
);

    import periph_pkg::*;

    localparam int NSLV = 3;

    localparam addr_t SLV0_BASE = addr_t'(SLV0_ADDR);
    localparam addr_t SLV0_END  = addr_t'(SLV0_ADDR + SLV0_SIZE);
    localparam addr_t SLV1_BASE = addr_t'(SLV1_ADDR);
    localparam addr_t SLV1_END  = addr_t'(SLV1_ADDR + SLV1_SIZE);
    localparam addr_t SLV2_BASE = addr_t'(SLV2_ADDR);
    localparam addr_t SLV2_END  = addr_t'(SLV2_ADDR + SLV2_SIZE);

    logic [NSLV-1:0] hit;
    logic [1:0]      sel;
    addr_t           sel_base;
    data_t           sel_rdata;
    logic            sel_ready;
    data_t           rdata_in [NSLV];
    logic [NSLV-1:0] ready_in;

    logic [NSLV-1:0] en_q;
    logic [NSLV-1:0] wr_q;
    addr_t           addr_q  [NSLV];
    data_t           wdata_q [NSLV];
    strb_t           strb_q  [NSLV];

    assign rdata_in[0] = mst0_rdata;
    assign rdata_in[1] = mst1_rdata;
    assign rdata_in[2] = mst2_rdata;
    assign ready_in    = {mst2_ready, mst1_ready, mst0_ready};

    assign hit[0] = (slv_addr >= SLV0_BASE) && (slv_addr < SLV0_END);
    assign hit[1] = (slv_addr >= SLV1_BASE) && (slv_addr < SLV1_END);
    assign hit[2] = (slv_addr >= SLV2_BASE) && (slv_addr < SLV2_END);

    // Checked last to first so window 0 has priority
    always_comb begin
        sel      = 2'd0;
        sel_base = SLV0_BASE;
        if (hit[2]) begin
            sel      = 2'd2;
            sel_base = SLV2_BASE;
        end
        if (hit[1]) begin
            sel      = 2'd1;
            sel_base = SLV1_BASE;
        end
        if (hit[0]) begin
            sel      = 2'd0;
            sel_base = SLV0_BASE;
        end
        sel_rdata = rdata_in[sel];
        sel_ready = ready_in[sel];
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            en_q      <= '0;
            wr_q      <= '0;
            addr_q    <= '{default: '0};
            wdata_q   <= '{default: '0};
            strb_q    <= '{default: '0};
            slv_rdata <= '0;
            slv_ready <= 1'b0;
        end else if (srst || !slv_en || slv_ready) begin
            // Idle between accesses
            en_q      <= '0;
            wr_q      <= '0;
            addr_q    <= '{default: '0};
            wdata_q   <= '{default: '0};
            strb_q    <= '{default: '0};
            slv_rdata <= '0;
            slv_ready <= 1'b0;
        end else if (|hit) begin
            for (int k = 0; k < NSLV; k++) begin
                if (sel == 2'(k)) begin
                    en_q[k]    <= !sel_ready;
                    wr_q[k]    <= slv_wr && !sel_ready;
                    addr_q[k]  <= slv_addr - sel_base;
                    wdata_q[k] <= slv_wdata;
                    strb_q[k]  <= slv_strb;
                end
            end
            slv_rdata <= sel_rdata;
            slv_ready <= sel_ready;
        end else begin
            // Nothing mapped here, complete with zero data
            slv_rdata <= '0;
            slv_ready <= 1'b1;
        end
    end

    assign mst0_en    = en_q[0];
    assign mst0_wr    = wr_q[0];
    assign mst0_addr  = addr_q[0];
    assign mst0_wdata = wdata_q[0];
    assign mst0_strb  = strb_q[0];
    assign mst1_en    = en_q[1];
    assign mst1_wr    = wr_q[1];
    assign mst1_addr  = addr_q[1];
    assign mst1_wdata = wdata_q[1];
    assign mst1_strb  = strb_q[1];
    assign mst2_en    = en_q[2];
    assign mst2_wr    = wr_q[2];
    assign mst2_addr  = addr_q[2];
    assign mst2_wdata = wdata_q[2];
    assign mst2_strb  = strb_q[2];

    // Only one target is addressed at a time
    assert property (@(posedge aclk) disable iff (!aresetn)
        $onehot0({mst2_en, mst1_en, mst0_en}));

    // A completed access is a single ready pulse
    assert property (@(posedge aclk) disable iff (!aresetn)
        slv_ready |=> !slv_ready);

endmodule

// File: src/scratch_ram.sv
// Scratch RAM target with byte-strobed writes

`timescale 1ns/100ps

module scratch_ram #(
    parameter int RAM_DEPTH = 8
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    input  logic              en,
    input  logic              wr,
    input  periph_pkg::addr_t addr,
    input  periph_pkg::data_t wdata,
    input  periph_pkg::strb_t strb,
    output periph_pkg::data_t rdata,
    output logic              ready
);

    import periph_pkg::*;

    localparam int IDXW = (RAM_DEPTH > 1) ? $clog2(RAM_DEPTH) : 1;

    data_t           mem [RAM_DEPTH];
    logic [IDXW-1:0] idx;
    logic            answer;

    assign idx    = addr[IDXW-1:0];
    assign answer = en && !ready;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            mem   <= '{default: '0};
            rdata <= '0;
            ready <= 1'b0;
        end else if (srst) begin
            mem   <= '{default: '0};
            rdata <= '0;
            ready <= 1'b0;
        end else begin
            ready <= answer;
            rdata <= '0;
            if (answer) begin
                if (wr) begin
                    mem[idx] <= strb_merge(mem[idx], wdata, strb);
                end else begin
                    rdata <= mem[idx];
                end
            end
        end
    end

    // Decoder window must fit the RAM
    assert property (@(posedge aclk) disable iff (!aresetn)
        en |-> addr < RAM_DEPTH);

endmodule

// File: src/gpio_regs.sv
// GPIO target: output, synchronized input, rising-edge status and mask
// registers, and the masked interrupt

`timescale 1ns/100ps

module gpio_regs (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    input  logic              en,
    input  logic              wr,
    input  periph_pkg::addr_t addr,
    input  periph_pkg::data_t wdata,
    input  periph_pkg::strb_t strb,
    output periph_pkg::data_t rdata,
    output logic              ready,
    input  periph_pkg::data_t gpio_in,
    output periph_pkg::data_t gpio_out,
    output logic              gpio_irq
);

    import periph_pkg::*;

    localparam addr_t OFF_OUT    = addr_t'(0);
    localparam addr_t OFF_IN     = addr_t'(1);
    localparam addr_t OFF_STATUS = addr_t'(2);
    localparam addr_t OFF_MASK   = addr_t'(3);

    data_t sync_q1;
    data_t sync_q2;
    data_t in_q;
    data_t out_q;
    data_t status_q;
    data_t mask_q;
    data_t rd_word;
    data_t clr;
    logic  answer;
    logic  wen;

    assign answer = en && !ready;
    assign wen    = answer && wr;

    always_comb begin
        case (addr)
            OFF_OUT:    rd_word = out_q;
            OFF_IN:     rd_word = in_q;
            OFF_STATUS: rd_word = status_q;
            OFF_MASK:   rd_word = mask_q;
            default:    rd_word = '0;
        endcase
    end

    // Write one to clear
    assign clr = (wen && addr == OFF_STATUS) ? (wdata & strb_mask(strb)) : '0;

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            in_q     <= '0;
            out_q    <= '0;
            status_q <= '0;
            mask_q   <= '0;
            rdata    <= '0;
            ready    <= 1'b0;
        end else if (srst) begin
            sync_q1  <= '0;
            sync_q2  <= '0;
            in_q     <= '0;
            out_q    <= '0;
            status_q <= '0;
            mask_q   <= '0;
            rdata    <= '0;
            ready    <= 1'b0;
        end else begin
            sync_q1  <= gpio_in;
            sync_q2  <= sync_q1;
            in_q     <= sync_q2;
            // a fresh edge beats a clear in the same cycle
            status_q <= (status_q & ~clr) | (sync_q2 & ~in_q);
            ready    <= answer;
            rdata    <= (answer && !wr) ? rd_word : '0;
            if (wen && addr == OFF_OUT) begin
                out_q <= strb_merge(out_q, wdata, strb);
            end
            if (wen && addr == OFF_MASK) begin
                mask_q <= strb_merge(mask_q, wdata, strb);
            end
        end
    end

    assign gpio_out = out_q;
    assign gpio_irq = |(status_q & mask_q);

endmodule

// File: src/timer_regs.sv
// Timer target: free-running counter, compare, sticky match status
// and interrupt

`timescale 1ns/100ps

module timer_regs (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    input  logic              en,
    input  logic              wr,
    input  periph_pkg::addr_t addr,
    input  periph_pkg::data_t wdata,
    input  periph_pkg::strb_t strb,
    output periph_pkg::data_t rdata,
    output logic              ready,
    output logic              timer_irq
);

    import periph_pkg::*;

    localparam addr_t OFF_CTRL   = addr_t'(0);
    localparam addr_t OFF_COUNT  = addr_t'(1);
    localparam addr_t OFF_CMP    = addr_t'(2);
    localparam addr_t OFF_STATUS = addr_t'(3);

    logic  ctrl_en;
    data_t count_q;
    data_t cmp_q;
    logic  status_q;
    data_t rd_word;
    logic  answer;
    logic  wen;
    logic  match;

    assign answer = en && !ready;
    assign wen    = answer && wr;
    assign match  = ctrl_en && (count_q == cmp_q);

    always_comb begin
        case (addr)
            OFF_CTRL:   rd_word = data_t'(ctrl_en);
            OFF_COUNT:  rd_word = count_q;
            OFF_CMP:    rd_word = cmp_q;
            OFF_STATUS: rd_word = data_t'(status_q);
            default:    rd_word = '0;
        endcase
    end

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ctrl_en  <= 1'b0;
            count_q  <= '0;
            cmp_q    <= '0;
            status_q <= 1'b0;
            rdata    <= '0;
            ready    <= 1'b0;
        end else if (srst) begin
            ctrl_en  <= 1'b0;
            count_q  <= '0;
            cmp_q    <= '0;
            status_q <= 1'b0;
            rdata    <= '0;
            ready    <= 1'b0;
        end else begin
            ready <= answer;
            rdata <= (answer && !wr) ? rd_word : '0;
            if (ctrl_en) begin
                count_q <= count_q + data_t'(1);
            end
            if (wen && addr == OFF_CTRL && strb[0]) begin
                ctrl_en <= wdata[0];
            end
            if (wen && addr == OFF_CMP) begin
                cmp_q <= strb_merge(cmp_q, wdata, strb);
            end
            // Match wins over a clear
            if (match) begin
                status_q <= 1'b1;
            end else if (wen && addr == OFF_STATUS && strb[0] && wdata[0]) begin
                status_q <= 1'b0;
            end
        end
    end

    assign timer_irq = status_q;

    // Counter holds while disabled
    assert property (@(posedge aclk) disable iff (!aresetn)
        !ctrl_en && !srst |=> count_q == $past(count_q));

endmodule

// File: src/periph_top.sv
// Peripheral subsystem: interconnect with scratch RAM, GPIO and timer targets

`timescale 1ns/100ps

module periph_top #(
    parameter int SLV0_ADDR = 0,
    parameter int SLV0_SIZE = 8,
    parameter int SLV1_ADDR = 8,
    parameter int SLV1_SIZE = 4,
    parameter int SLV2_ADDR = 12,
    parameter int SLV2_SIZE = 4
) (
    input  logic              aclk,
    input  logic              aresetn,
    input  logic              srst,
    input  logic              slv_en,
    input  logic              slv_wr,
    input  periph_pkg::addr_t slv_addr,
    input  periph_pkg::data_t slv_wdata,
    input  periph_pkg::strb_t slv_strb,
    output periph_pkg::data_t slv_rdata,
    output logic              slv_ready,
    input  periph_pkg::data_t gpio_in,
    output periph_pkg::data_t gpio_out,
    output logic              gpio_irq,
    output logic              timer_irq
);

    import periph_pkg::*;

    logic  mst0_en;
    logic  mst0_wr;
    addr_t mst0_addr;
    data_t mst0_wdata;
    strb_t mst0_strb;
    data_t mst0_rdata;
    logic  mst0_ready;

    logic  mst1_en;
    logic  mst1_wr;
    addr_t mst1_addr;
    data_t mst1_wdata;
    strb_t mst1_strb;
    data_t mst1_rdata;
    logic  mst1_ready;

    logic  mst2_en;
    logic  mst2_wr;
    addr_t mst2_addr;
    data_t mst2_wdata;
    strb_t mst2_strb;
    data_t mst2_rdata;
    logic  mst2_ready;

    apb_interconnect #(
        .SLV0_ADDR (SLV0_ADDR),
        .SLV0_SIZE (SLV0_SIZE),
        .SLV1_ADDR (SLV1_ADDR),
        .SLV1_SIZE (SLV1_SIZE),
        .SLV2_ADDR (SLV2_ADDR),
        .SLV2_SIZE (SLV2_SIZE)
    ) apb_interconnect_inst (.*);

    // RAM depth follows its window
    scratch_ram #(
        .RAM_DEPTH (SLV0_SIZE)
    ) scratch_ram_inst (
        .aclk  (aclk),       .aresetn (aresetn),    .srst (srst),
        .en    (mst0_en),    .wr      (mst0_wr),    .addr (mst0_addr),
        .wdata (mst0_wdata), .strb    (mst0_strb),
        .rdata (mst0_rdata), .ready   (mst0_ready)
    );

    gpio_regs gpio_regs_inst (
        .aclk     (aclk),       .aresetn (aresetn),    .srst (srst),
        .en       (mst1_en),    .wr      (mst1_wr),    .addr (mst1_addr),
        .wdata    (mst1_wdata), .strb    (mst1_strb),
        .rdata    (mst1_rdata), .ready   (mst1_ready),
        .gpio_in  (gpio_in),    .gpio_out (gpio_out),  .gpio_irq (gpio_irq)
    );

    timer_regs timer_regs_inst (
        .aclk      (aclk),       .aresetn (aresetn),    .srst (srst),
        .en        (mst2_en),    .wr      (mst2_wr),    .addr (mst2_addr),
        .wdata     (mst2_wdata), .strb    (mst2_strb),
        .rdata     (mst2_rdata), .ready   (mst2_ready),
        .timer_irq (timer_irq)
    );

endmodule

// File: tb/periph_tb.sv
// Trace-driven testbench for the peripheral subsystem: clock, reset,
// bus access, interrupt waits and value checks

`timescale 1ns/100ps

module periph_tb;

    import periph_pkg::*;

    localparam int    CLK_HALF     = 2;
    localparam int    RESET_CYCLES = 4;
    localparam int    ACC_TIMEOUT  = 16;
    localparam int    IRQ_TIMEOUT  = 200;
    // Windows 0-7, 8-11 and 12-15 cover every address below 16
    localparam addr_t MAP_END      = 16'd16;

    logic  aclk;
    logic  aresetn;
    logic  srst;
    logic  slv_en;
    logic  slv_wr;
    addr_t slv_addr;
    data_t slv_wdata;
    strb_t slv_strb;
    data_t slv_rdata;
    logic  slv_ready;
    data_t gpio_in;
    data_t gpio_out;
    logic  gpio_irq;
    logic  timer_irq;

    int    step;
    data_t prev_capture;

    periph_top periph_top_inst (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .srst      (srst),
        .slv_en    (slv_en),
        .slv_wr    (slv_wr),
        .slv_addr  (slv_addr),
        .slv_wdata (slv_wdata),
        .slv_strb  (slv_strb),
        .slv_rdata (slv_rdata),
        .slv_ready (slv_ready),
        .gpio_in   (gpio_in),
        .gpio_out  (gpio_out),
        .gpio_irq  (gpio_irq),
        .timer_irq (timer_irq)
    );

    always #CLK_HALF aclk = ~aclk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input data_t expected, input data_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED %s expected 0x%08h actual 0x%08h",
                                name, expected, actual));
        end
    endtask

    // Stops on a trace line with missing or unreadable fields
    task automatic require_fields(input int got, input int want);
        if (got != want) begin
            abort_run($sformatf("step %0d: trace line gave %0d fields instead of %0d",
                                step, got, want));
        end
    endtask

    // One access; drives on the rising edge, samples on the falling edge
    task automatic bus_access(input logic wr, input addr_t addr, input data_t wdata,
                              input strb_t strb, output data_t rd);
        int   cycles;
        logic done;
        cycles = 0;
        done   = 1'b0;
        @(posedge aclk);
        slv_en    <= 1'b1;
        slv_wr    <= wr;
        slv_addr  <= addr;
        slv_wdata <= wdata;
        slv_strb  <= strb;
        while (!done) begin
            @(posedge aclk);
            cycles++;
            @(negedge aclk);
            if (slv_ready) begin
                done = 1'b1;
            end else if (cycles >= ACC_TIMEOUT) begin
                abort_run($sformatf("no ready within %0d cycles for address 0x%04h",
                                    ACC_TIMEOUT, addr));
            end
        end
        rd = slv_rdata;
        // Mapped accesses take three cycles, unmapped ones complete at once
        check_value($sformatf("step %0d latency at 0x%04h", step, addr),
                    (addr < MAP_END) ? 32'd3 : 32'd1, data_t'(cycles));
        @(posedge aclk);
        slv_en    <= 1'b0;
        slv_wr    <= 1'b0;
        slv_addr  <= '0;
        slv_wdata <= '0;
        slv_strb  <= '0;
    endtask

    task automatic wait_irq(input logic use_timer, input logic level);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(negedge aclk);
            cycles++;
            seen = ((use_timer ? timer_irq : gpio_irq) == level);
            if (!seen && cycles >= IRQ_TIMEOUT) begin
                abort_run($sformatf("step %0d: %0s interrupt did not reach level %0d",
                                    step, use_timer ? "timer" : "gpio", level));
            end
        end
    endtask

    initial begin
        int               fd;
        int               code;
        logic [8*16-1:0]  tok;
        logic [8*16-1:0]  arg;
        logic [8*128-1:0] rest;
        data_t            a;
        data_t            d;
        data_t            s;
        data_t            rd;
        aclk         = 1'b0;
        aresetn      = 1'b0;
        srst         = 1'b0;
        slv_en       = 1'b0;
        slv_wr       = 1'b0;
        slv_addr     = '0;
        slv_wdata    = '0;
        slv_strb     = '0;
        gpio_in      = '0;
        step         = 0;
        prev_capture = '0;
        fd = $fopen("tb/periph_trace.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open trace file tb/periph_trace.txt");
        end
        repeat (RESET_CYCLES) @(posedge aclk);
        aresetn <= 1'b1;
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok == "#") begin
                code = $fgets(rest, fd);
            end else begin
                step++;
                if (tok == "W") begin
                    code = $fscanf(fd, "%h %h %h", a, d, s);
                    require_fields(code, 3);
                    bus_access(1'b1, addr_t'(a), d, strb_t'(s), rd);
                end else if (tok == "R") begin
                    code = $fscanf(fd, "%h %h", a, d);
                    require_fields(code, 2);
                    bus_access(1'b0, addr_t'(a), '0, '0, rd);
                    check_value($sformatf("step %0d read 0x%04h", step, a[15:0]), d, rd);
                end else if (tok == "G") begin
                    code = $fscanf(fd, "%h", a);
                    require_fields(code, 1);
                    @(posedge aclk);
                    gpio_in <= a;
                end else if (tok == "O") begin
                    code = $fscanf(fd, "%h", d);
                    require_fields(code, 1);
                    @(negedge aclk);
                    check_value($sformatf("step %0d gpio_out", step), d, gpio_out);
                end else if (tok == "I") begin
                    code = $fscanf(fd, "%s %h", arg, a);
                    require_fields(code, 2);
                    if (arg == "timer") begin
                        wait_irq(1'b1, a[0]);
                    end else if (arg == "gpio") begin
                        wait_irq(1'b0, a[0]);
                    end else begin
                        abort_run($sformatf("step %0d names an unknown interrupt", step));
                    end
                end else if (tok == "T") begin
                    code = $fscanf(fd, "%h", a);
                    require_fields(code, 1);
                    repeat (a) @(posedge aclk);
                end else if (tok == "S") begin
                    code = $fscanf(fd, "%h", a);
                    require_fields(code, 1);
                    @(posedge aclk);
                    srst <= 1'b1;
                    repeat (a) @(posedge aclk);
                    srst <= 1'b0;
                end else if (tok == "C") begin
                    code = $fscanf(fd, "%h %s", a, arg);
                    require_fields(code, 2);
                    bus_access(1'b0, addr_t'(a), '0, '0, rd);
                    if (arg == "E") begin
                        check_value($sformatf("step %0d same value at 0x%04h", step, a[15:0]),
                                    prev_capture, rd);
                    end else if (arg == "G") begin
                        check_value($sformatf("step %0d 0x%08h above 0x%08h", step, rd,
                                              prev_capture), 32'd1, data_t'(rd > prev_capture));
                    end
                    prev_capture = rd;
                end else begin
                    abort_run($sformatf("unknown trace command %0s at step %0d", tok, step));
                end
            end
        end
        $fclose(fd);
        if (step == 0) begin
            abort_run("trace file held no commands");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

// File: tb/periph_trace.txt
# Columns: command, then hex fields
# W addr data strb | R addr expect | G gpio_in | O gpio_out | I gpio/timer level
# T cycles | S srst cycles | C addr N/E/G (capture, equal to or above last capture)
# Scratch RAM words and a strobed merge
W 0000 11223344 f
W 0007 cafef00d f
R 0000 11223344
R 0007 cafef00d
W 0000 aabbccdd 5
R 0000 11bb33dd
# Window edges and an unmapped address
W 000b 000000ff f
R 000b 000000ff
R 000c 00000000
R 000f 00000000
W 0010 12345678 f
R 0010 00000000
R 0007 cafef00d
R 0000 11bb33dd
# GPIO output with a lane 1 write
W 0008 a5a5a5a5 f
W 0008 00003c00 2
O a5a53ca5
R 0008 a5a53ca5
# GPIO input, unmasked edges, then a masked edge
G 00f00000
T 3
R 0009 00f00000
R 000a 00f00000
I gpio 0
W 000a 00f00000 f
R 000a 00000000
G 00f00001
I gpio 1
R 000a 00000001
R 0009 00f00001
W 000a 00000001 f
I gpio 0
R 000a 00000000
# Timer held, then counting up to compare
C 000d N
T 4
C 000d E
W 000e 00000010 f
W 000c 00000001 1
C 000d N
I timer 1
C 000d G
R 000f 00000001
W 000f 00000001 1
I timer 0
R 000f 00000000
W 000c 00000000 1
C 000d N
T 5
C 000d E
# Synchronous clear with quiet inputs
G 00000000
T 4
S 2
R 0000 00000000
R 0007 00000000
R 0008 00000000
O 00000000
R 0009 00000000
R 000a 00000000
R 000b 00000000
R 000c 00000000
R 000d 00000000
R 000e 00000000
R 000f 00000000
I gpio 0
I timer 0

// File: periph_top.f
src/periph_pkg.sv
src/apb_interconnect.sv
src/scratch_ram.sv
src/gpio_regs.sv
src/timer_regs.sv
src/periph_top.sv
tb/periph_tb.sv
